//--- verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

   // widths that carry a meaning
   typedef logic [7:0]  data_t;
   typedef logic [15:0] addr_t;
   typedef logic [7:0]  instr_t;
   typedef logic [2:0]  cyc_t;

   // first opcode fetch after reset, there is no vector
   localparam addr_t RESET_PC = 16'h0200;

   // cc field of an aaabbbcc opcode
   localparam logic [1:0] CC_MISC  = 2'b00;
   localparam logic [1:0] CC_ARITH = 2'b01;
   localparam logic [1:0] CC_REG   = 2'b10;

   typedef enum logic {BUS_READ, BUS_WRITE} bus_rw_e;

   // IDL_LOW means zero page, high byte forced to zero
   typedef enum logic [1:0] {ADDR_PC, ADDR_IDL_LOW, ADDR_IDL} addr_src_e;

   typedef enum logic [1:0] {WDATA_A, WDATA_X, WDATA_Y} wdata_src_e;

   // PC_JUMP loads {read data, idl low}
   typedef enum logic [1:0] {PC_HOLD, PC_INC, PC_JUMP} pc_op_e;

   typedef enum logic [1:0] {IDL_HOLD, IDL_LOAD_LOW, IDL_LOAD_HIGH} idl_op_e;

   // codes 0-3, 5 and 6 line up with aaa of the cc=01 group
   typedef enum logic [2:0] {
      ALU_OR  = 3'd0,
      ALU_AND = 3'd1,
      ALU_EOR = 3'd2,
      ALU_ADC = 3'd3,
      ALU_INC = 3'd4,
      ALU_FWD = 3'd5,
      ALU_CMP = 3'd6,
      ALU_DEC = 3'd7
   } alu_op_e;

   typedef enum logic [1:0] {OP1_A, OP1_X, OP1_Y} op1_src_e;

   typedef enum logic [1:0] {OP2_DATA, OP2_A, OP2_X, OP2_Y} op2_src_e;

   typedef enum logic [1:0] {DEST_NONE, DEST_A, DEST_X, DEST_Y} dest_e;

   typedef enum logic [1:0] {FLAG_HOLD, FLAG_ALU, FLAG_CLC, FLAG_SEC} flag_op_e;

   // one microcode step
   typedef struct packed {
      bus_rw_e    rw;
      addr_src_e  addr_src;
      wdata_src_e wdata_src;
      pc_op_e     pc_op;
      idl_op_e    idl_op;
      alu_op_e    alu_op;
      op1_src_e   op1_src;
      op2_src_e   op2_src;
      dest_e      dest;
      flag_op_e   flag_op;
      logic       last_step;
   } ctrl_word_t;

   typedef struct packed {
      bus_rw_e rw;
      addr_t   addr;
      data_t   wdata;
   } bus_req_t;

endpackage

`default_nettype wire

//--- verilog/cpu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_alu (
   input  wire cpu_pkg::alu_op_e op,
   input  wire cpu_pkg::data_t   a,
   input  wire cpu_pkg::data_t   b,
   input  wire                   carry_in,
   output cpu_pkg::data_t        result,
   output logic                  carry_out,
   output logic                  zero,
   output logic                  negative,
   output logic                  overflow
);

   logic [8:0] sum;
   logic [8:0] diff;

   assign sum  = {1'b0, a} + {1'b0, b} + {8'h00, carry_in};
   assign diff = {1'b0, a} - {1'b0, b};

   always_comb begin
      carry_out = carry_in;
      overflow  = 1'b0;
      case (op)
         cpu_pkg::ALU_OR:  result = a | b;
         cpu_pkg::ALU_AND: result = a & b;
         cpu_pkg::ALU_EOR: result = a ^ b;
         cpu_pkg::ALU_ADC: begin
            result    = sum[7:0];
            carry_out = sum[8];
            // same sign in, other sign out
            overflow  = (a[7] == b[7]) && (sum[7] != a[7]);
         end
         // carry set means no borrow
         cpu_pkg::ALU_CMP: begin
            result    = diff[7:0];
            carry_out = ~diff[8];
         end
         cpu_pkg::ALU_INC: result = a + 8'd1;
         cpu_pkg::ALU_DEC: result = a - 8'd1;
         default:          result = b;
      endcase
   end

   assign zero     = (result == 8'h00);
   assign negative = result[7];

endmodule

`default_nettype wire

//--- verilog/cpu_ctrl_rom.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_ctrl_rom (
   input  wire cpu_pkg::instr_t  instr,
   input  wire cpu_pkg::cyc_t    cyc,
   output cpu_pkg::ctrl_word_t   ctrl
);

   logic [2:0]          aaa;
   logic [2:0]          bbb;
   logic [1:0]          cc;
   logic                arith_ok;
   logic                op_step;
   cpu_pkg::dest_e      idx_dest;
   cpu_pkg::wdata_src_e idx_wdata;

   always_comb begin
      aaa = instr[7:5];
      bbb = instr[4:2];
      cc  = instr[1:0];

      // SBC is dropped, STA # does not exist
      arith_ok = (aaa != 3'b111) && !(aaa == 3'b100 && bbb == 3'b010);
      op_step  = 1'b0;

      // LDX/STX and LDY/STY differ only in the index register
      idx_dest  = (cc == cpu_pkg::CC_REG) ? cpu_pkg::DEST_X : cpu_pkg::DEST_Y;
      idx_wdata = (cc == cpu_pkg::CC_REG) ? cpu_pkg::WDATA_X : cpu_pkg::WDATA_Y;

      // default is a one step NOP with a dummy read at PC
      ctrl.rw        = cpu_pkg::BUS_READ;
      ctrl.addr_src  = cpu_pkg::ADDR_PC;
      ctrl.wdata_src = cpu_pkg::WDATA_A;
      ctrl.pc_op     = cpu_pkg::PC_HOLD;
      ctrl.idl_op    = cpu_pkg::IDL_HOLD;
      ctrl.alu_op    = cpu_pkg::ALU_FWD;
      ctrl.op1_src   = cpu_pkg::OP1_A;
      ctrl.op2_src   = cpu_pkg::OP2_DATA;
      ctrl.dest      = cpu_pkg::DEST_NONE;
      ctrl.flag_op   = cpu_pkg::FLAG_HOLD;
      ctrl.last_step = 1'b1;

      if (cyc == '0) begin
         // opcode fetch
         ctrl.pc_op     = cpu_pkg::PC_INC;
         ctrl.last_step = 1'b0;
      end else if (cc == cpu_pkg::CC_ARITH) begin
         if (arith_ok) begin
            case (bbb)
               // immediate
               3'b010: begin
                  op_step    = 1'b1;
                  ctrl.pc_op = cpu_pkg::PC_INC;
               end
               // zero page
               3'b001: begin
                  if (cyc == 3'd1) begin
                     ctrl.pc_op     = cpu_pkg::PC_INC;
                     ctrl.idl_op    = cpu_pkg::IDL_LOAD_LOW;
                     ctrl.last_step = 1'b0;
                  end else begin
                     op_step       = 1'b1;
                     ctrl.addr_src = cpu_pkg::ADDR_IDL_LOW;
                  end
               end
               // absolute
               3'b011: begin
                  if (cyc == 3'd1 || cyc == 3'd2) begin
                     ctrl.pc_op     = cpu_pkg::PC_INC;
                     ctrl.idl_op    = (cyc == 3'd1) ? cpu_pkg::IDL_LOAD_LOW
                                                    : cpu_pkg::IDL_LOAD_HIGH;
                     ctrl.last_step = 1'b0;
                  end else begin
                     op_step       = 1'b1;
                     ctrl.addr_src = cpu_pkg::ADDR_IDL;
                  end
               end
               default: ;
            endcase
         end

         // the step that touches the operand
         if (op_step) begin
            if (aaa == 3'b100) begin
               ctrl.rw = cpu_pkg::BUS_WRITE;
            end else begin
               ctrl.alu_op  = cpu_pkg::alu_op_e'(aaa);
               ctrl.flag_op = cpu_pkg::FLAG_ALU;
               // CMP only sets flags
               ctrl.dest    = (aaa == 3'b110) ? cpu_pkg::DEST_NONE : cpu_pkg::DEST_A;
            end
         end
      end else begin
         case ({cc, aaa, bbb})
            // LDY #, LDX #
            {cpu_pkg::CC_MISC, 6'b101_000}, {cpu_pkg::CC_REG, 6'b101_000}: begin
               ctrl.pc_op   = cpu_pkg::PC_INC;
               ctrl.dest    = idx_dest;
               ctrl.flag_op = cpu_pkg::FLAG_ALU;
            end
            // STY zpg, STX zpg
            {cpu_pkg::CC_MISC, 6'b100_001}, {cpu_pkg::CC_REG, 6'b100_001}: begin
               if (cyc == 3'd1) begin
                  ctrl.pc_op     = cpu_pkg::PC_INC;
                  ctrl.idl_op    = cpu_pkg::IDL_LOAD_LOW;
                  ctrl.last_step = 1'b0;
               end else begin
                  ctrl.rw        = cpu_pkg::BUS_WRITE;
                  ctrl.addr_src  = cpu_pkg::ADDR_IDL_LOW;
                  ctrl.wdata_src = idx_wdata;
               end
            end
            // JMP abs
            {cpu_pkg::CC_MISC, 6'b010_011}: begin
               if (cyc == 3'd1) begin
                  ctrl.pc_op     = cpu_pkg::PC_INC;
                  ctrl.idl_op    = cpu_pkg::IDL_LOAD_LOW;
                  ctrl.last_step = 1'b0;
               end else begin
                  ctrl.pc_op = cpu_pkg::PC_JUMP;
               end
            end
            // TYA, TXA
            {cpu_pkg::CC_MISC, 6'b100_110}, {cpu_pkg::CC_REG, 6'b100_010}: begin
               ctrl.op2_src = (cc == cpu_pkg::CC_REG) ? cpu_pkg::OP2_X : cpu_pkg::OP2_Y;
               ctrl.dest    = cpu_pkg::DEST_A;
               ctrl.flag_op = cpu_pkg::FLAG_ALU;
            end
            // TAY, TAX
            {cpu_pkg::CC_MISC, 6'b101_010}, {cpu_pkg::CC_REG, 6'b101_010}: begin
               ctrl.op2_src = cpu_pkg::OP2_A;
               ctrl.dest    = idx_dest;
               ctrl.flag_op = cpu_pkg::FLAG_ALU;
            end
            // INY, DEY
            {cpu_pkg::CC_MISC, 6'b110_010}, {cpu_pkg::CC_MISC, 6'b100_010}: begin
               ctrl.alu_op  = aaa[1] ? cpu_pkg::ALU_INC : cpu_pkg::ALU_DEC;
               ctrl.op1_src = cpu_pkg::OP1_Y;
               ctrl.dest    = cpu_pkg::DEST_Y;
               ctrl.flag_op = cpu_pkg::FLAG_ALU;
            end
            // INX, DEX
            {cpu_pkg::CC_MISC, 6'b111_010}, {cpu_pkg::CC_REG, 6'b110_010}: begin
               ctrl.alu_op  = (cc == cpu_pkg::CC_MISC) ? cpu_pkg::ALU_INC : cpu_pkg::ALU_DEC;
               ctrl.op1_src = cpu_pkg::OP1_X;
               ctrl.dest    = cpu_pkg::DEST_X;
               ctrl.flag_op = cpu_pkg::FLAG_ALU;
            end
            // CLC, SEC
            {cpu_pkg::CC_MISC, 6'b000_110}, {cpu_pkg::CC_MISC, 6'b001_110}: begin
               ctrl.flag_op = aaa[0] ? cpu_pkg::FLAG_SEC : cpu_pkg::FLAG_CLC;
            end
            // NOP and everything unknown
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- verilog/cpu_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_sequencer (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire                      step_done,
   input  wire cpu_pkg::data_t      rdata,
   input  wire cpu_pkg::ctrl_word_t ctrl,
   output cpu_pkg::instr_t          instr,
   output cpu_pkg::cyc_t            cyc
);

   // everything waits for the bus step to complete
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         instr <= '0;
         cyc   <= '0;
      end else if (step_done) begin
         // step 0 is the fetch, keep the opcode
         if (cyc == '0) begin
            instr <= rdata;
         end

         if (ctrl.last_step) begin
            cyc <= '0;
         end else begin
            cyc <= cyc + 3'd1;
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/cpu_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_datapath (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire cpu_pkg::ctrl_word_t ctrl,
   input  wire                      step_done,
   input  wire cpu_pkg::data_t      rdata,
   output cpu_pkg::bus_req_t        bus_req
);

   cpu_pkg::data_t a;
   cpu_pkg::data_t x;
   cpu_pkg::data_t y;
   cpu_pkg::addr_t pc;
   cpu_pkg::addr_t idl;
   logic           flag_n;
   logic           flag_z;
   logic           flag_c;
   logic           flag_v;

   cpu_pkg::data_t op1;
   cpu_pkg::data_t op2;
   cpu_pkg::data_t alu_result;
   logic           alu_carry;
   logic           alu_zero;
   logic           alu_negative;
   logic           alu_overflow;

   always_comb begin
      case (ctrl.op1_src)
         cpu_pkg::OP1_X: op1 = x;
         cpu_pkg::OP1_Y: op1 = y;
         default:        op1 = a;
      endcase

      case (ctrl.op2_src)
         cpu_pkg::OP2_A: op2 = a;
         cpu_pkg::OP2_X: op2 = x;
         cpu_pkg::OP2_Y: op2 = y;
         default:        op2 = rdata;
      endcase
   end

   cpu_alu alu_inst (
      .op        (ctrl.alu_op),
      .a         (op1),
      .b         (op2),
      .carry_in  (flag_c),
      .result    (alu_result),
      .carry_out (alu_carry),
      .zero      (alu_zero),
      .negative  (alu_negative),
      .overflow  (alu_overflow)
   );

   // registers only move when the bus step completes
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         a      <= '0;
         x      <= '0;
         y      <= '0;
         pc     <= cpu_pkg::RESET_PC;
         flag_n <= 1'b0;
         flag_z <= 1'b0;
         flag_c <= 1'b0;
         flag_v <= 1'b0;
      end else if (step_done) begin
         case (ctrl.dest)
            cpu_pkg::DEST_A: a <= alu_result;
            cpu_pkg::DEST_X: x <= alu_result;
            cpu_pkg::DEST_Y: y <= alu_result;
            default: ;
         endcase

         case (ctrl.pc_op)
            cpu_pkg::PC_INC:  pc <= pc + 16'd1;
            cpu_pkg::PC_JUMP: pc <= {rdata, idl[7:0]};
            default: ;
         endcase

         case (ctrl.flag_op)
            cpu_pkg::FLAG_ALU: begin
               flag_n <= alu_negative;
               flag_z <= alu_zero;
               // only ADC and CMP own the carry
               if (ctrl.alu_op == cpu_pkg::ALU_ADC || ctrl.alu_op == cpu_pkg::ALU_CMP) begin
                  flag_c <= alu_carry;
               end
               if (ctrl.alu_op == cpu_pkg::ALU_ADC) begin
                  flag_v <= alu_overflow;
               end
            end
            cpu_pkg::FLAG_CLC: flag_c <= 1'b0;
            cpu_pkg::FLAG_SEC: flag_c <= 1'b1;
            default: ;
         endcase
      end
   end

   // operand address latch
   always_ff @(posedge clk) begin
      if (step_done) begin
         case (ctrl.idl_op)
            cpu_pkg::IDL_LOAD_LOW:  idl[7:0]  <= rdata;
            cpu_pkg::IDL_LOAD_HIGH: idl[15:8] <= rdata;
            default: ;
         endcase
      end
   end

   always_comb begin
      bus_req.rw = ctrl.rw;

      case (ctrl.addr_src)
         cpu_pkg::ADDR_IDL_LOW: bus_req.addr = {8'h00, idl[7:0]};
         cpu_pkg::ADDR_IDL:     bus_req.addr = idl;
         default:               bus_req.addr = pc;
      endcase

      case (ctrl.wdata_src)
         cpu_pkg::WDATA_X: bus_req.wdata = x;
         cpu_pkg::WDATA_Y: bus_req.wdata = y;
         default:          bus_req.wdata = a;
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/cpu_apb_master.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_apb_master (
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire cpu_pkg::bus_req_t bus_req,
   output logic                   psel,
   output logic                   penable,
   output logic                   pwrite,
   output cpu_pkg::addr_t         paddr,
   output cpu_pkg::data_t         pwdata,
   input  wire cpu_pkg::data_t    prdata,
   input  wire                    pready,
   output logic                   step_done,
   output cpu_pkg::data_t         rdata
);

   typedef enum logic {ST_SETUP, ST_ACCESS} apb_state_e;

   apb_state_e state;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ST_SETUP;
         psel  <= 1'b0;
      end else begin
         // the core always has a request pending
         psel <= 1'b1;
         case (state)
            ST_SETUP:  if (psel) state <= ST_ACCESS;
            ST_ACCESS: if (pready) state <= ST_SETUP;
            default:   state <= ST_SETUP;
         endcase
      end
   end

   assign penable = (state == ST_ACCESS);

   // the request only changes on step_done so it holds through the transfer
   assign pwrite = (bus_req.rw == cpu_pkg::BUS_WRITE);
   assign paddr  = bus_req.addr;
   assign pwdata = bus_req.wdata;

   assign step_done = penable && pready;
   assign rdata     = prdata;

endmodule

`default_nettype wire

//--- verilog/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
   input  wire                 clk,
   input  wire                 rst_n,
   output logic                psel,
   output logic                penable,
   output logic                pwrite,
   output cpu_pkg::addr_t      paddr,
   output cpu_pkg::data_t      pwdata,
   input  wire cpu_pkg::data_t prdata,
   input  wire                 pready
);

   cpu_pkg::ctrl_word_t ctrl;
   cpu_pkg::bus_req_t   bus_req;
   cpu_pkg::instr_t     instr;
   cpu_pkg::cyc_t       cyc;
   cpu_pkg::data_t      rdata;
   logic                step_done;

   cpu_apb_master apb_master_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .bus_req   (bus_req),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready),
      .step_done (step_done),
      .rdata     (rdata)
   );

   cpu_sequencer sequencer_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .step_done (step_done),
      .rdata     (rdata),
      .ctrl      (ctrl),
      .instr     (instr),
      .cyc       (cyc)
   );

   cpu_ctrl_rom ctrl_rom_inst (
      .instr (instr),
      .cyc   (cyc),
      .ctrl  (ctrl)
   );

   cpu_datapath datapath_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .ctrl      (ctrl),
      .step_done (step_done),
      .rdata     (rdata),
      .bus_req   (bus_req)
   );

endmodule

`default_nettype wire

//--- sim/apb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module apb_mem_model (
   input  wire                 clk,
   input  wire                 psel,
   input  wire                 penable,
   input  wire                 pwrite,
   input  wire cpu_pkg::addr_t paddr,
   input  wire cpu_pkg::data_t pwdata,
   output cpu_pkg::data_t      prdata,
   output logic                pready,
   // back-pressure and program loader
   input  wire                 wait_en,
   input  wire                 load_en,
   input  wire cpu_pkg::addr_t load_addr,
   input  wire cpu_pkg::data_t load_data,
   input  wire                 log_clear,
   output logic [7:0]          write_count
);

   cpu_pkg::data_t mem [0:65535];
   // every completed write, in bus order
   cpu_pkg::addr_t log_addr [0:255];
   cpu_pkg::data_t log_data [0:255];
   logic [1:0]     wait_left;
   integer         seed;

   initial begin
      seed = 32'h3ae4;
   end

   assign prdata = mem[paddr];
   // wait states count down in the access phase
   assign pready = (wait_left == 2'd0);

   always @(posedge clk) begin
      if (load_en) begin
         mem[load_addr] <= load_data;
      end else if (psel && penable && pready && pwrite) begin
         mem[paddr] <= pwdata;
      end

      if (log_clear) begin
         write_count <= '0;
      end else if (psel && penable && pready && pwrite) begin
         log_addr[write_count] <= paddr;
         log_data[write_count] <= pwdata;
         write_count           <= write_count + 8'd1;
      end

      // new wait count drawn in every setup phase
      if (psel && !penable) begin
         wait_left <= wait_en ? 2'($random(seed)) : 2'd0;
      end else if (psel && penable && !pready) begin
         wait_left <= wait_left - 2'd1;
      end
   end

endmodule

`default_nettype wire

//--- sim/tb_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top;

   logic           clk;
   logic           rst_n;
   logic           psel;
   logic           penable;
   logic           pwrite;
   cpu_pkg::addr_t paddr;
   cpu_pkg::data_t pwdata;
   cpu_pkg::data_t prdata;
   logic           pready;

   // memory model controls
   logic           wait_en;
   logic           load_en;
   cpu_pkg::addr_t load_addr;
   cpu_pkg::data_t load_data;
   logic           log_clear;
   logic [7:0]     write_count;

   int             value_errors;
   int             timeout_errors;

   // open APB transfer as seen on the last rising edge
   logic           xfer_open;
   cpu_pkg::addr_t xfer_addr;
   logic           xfer_write;

   // program image, operand bytes and expected writes of one test
   cpu_pkg::data_t prog [$];
   cpu_pkg::addr_t data_addr [$];
   cpu_pkg::data_t data_val [$];
   cpu_pkg::addr_t exp_addr [$];
   cpu_pkg::data_t exp_data [$];

   cpu_top cpu_top_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready)
   );

   apb_mem_model mem_model_inst (
      .clk         (clk),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pready      (pready),
      .wait_en     (wait_en),
      .load_en     (load_en),
      .load_addr   (load_addr),
      .load_data   (load_data),
      .log_clear   (log_clear),
      .write_count (write_count)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic check_addr(input cpu_pkg::addr_t got, input cpu_pkg::addr_t want,
                             input string what);
      if (got !== want) begin
         value_errors++;
         $display("FAILED at %0t: %s address %h, expected %h", $time, what, got, want);
      end
   endtask

   task automatic check_data(input cpu_pkg::data_t got, input cpu_pkg::data_t want,
                             input string what);
      if (got !== want) begin
         value_errors++;
         $display("FAILED at %0t: %s data %h, expected %h", $time, what, got, want);
      end
   endtask

   task automatic check_bit(input logic got, input logic want, input string what);
      if (got !== want) begin
         value_errors++;
         $display("FAILED at %0t: %s %b, expected %b", $time, what, got, want);
      end
   endtask

   // a setup phase leads into access phases that keep the same request
   always @(posedge clk) begin
      if (rst_n && xfer_open) begin
         check_bit(psel, 1'b1, "psel in access phase");
         check_bit(penable, 1'b1, "penable in access phase");
         check_addr(paddr, xfer_addr, "APB access phase");
         check_bit(pwrite, xfer_write, "pwrite in access phase");
      end
      xfer_open  = rst_n && psel && !(penable && pready);
      xfer_addr  = paddr;
      xfer_write = pwrite;
   end

   task automatic new_program();
      prog.delete();
      data_addr.delete();
      data_val.delete();
      exp_addr.delete();
      exp_data.delete();
   endtask

   function automatic cpu_pkg::addr_t here();
      return cpu_pkg::RESET_PC + 16'(prog.size());
   endfunction

   task automatic op_implied(input cpu_pkg::data_t opc);
      prog.push_back(opc);
   endtask

   task automatic op_byte(input cpu_pkg::data_t opc, input cpu_pkg::data_t arg);
      prog.push_back(opc);
      prog.push_back(arg);
   endtask

   // little endian operand
   task automatic op_word(input cpu_pkg::data_t opc, input cpu_pkg::addr_t arg);
      prog.push_back(opc);
      prog.push_back(arg[7:0]);
      prog.push_back(arg[15:8]);
   endtask

   task automatic place_data(input cpu_pkg::addr_t addr, input cpu_pkg::data_t val);
      data_addr.push_back(addr);
      data_val.push_back(val);
   endtask

   task automatic expect_write(input cpu_pkg::addr_t addr, input cpu_pkg::data_t val);
      exp_addr.push_back(addr);
      exp_data.push_back(val);
   endtask

   // ORA, AND, EOR and ADC as the 6502 defines them
   function automatic cpu_pkg::data_t arith_result(input logic [2:0] aaa,
                                                   input cpu_pkg::data_t acc,
                                                   input cpu_pkg::data_t m,
                                                   input logic carry);
      case (aaa)
         3'b000:  return acc | m;
         3'b001:  return acc & m;
         3'b010:  return acc ^ m;
         default: return acc + m + {7'd0, carry};
      endcase
   endfunction

   task automatic run_program(input string name);
      int n;
      int cycles;
      n = exp_addr.size();
      // every program ends in a jump to itself
      op_word(8'h4c, here());
      @(negedge clk);
      rst_n     = 1'b0;
      log_clear = 1'b1;
      load_en   = 1'b1;
      foreach (prog[i]) begin
         load_addr = cpu_pkg::RESET_PC + 16'(i);
         load_data = prog[i];
         @(negedge clk);
      end
      foreach (data_addr[i]) begin
         load_addr = data_addr[i];
         load_data = data_val[i];
         @(negedge clk);
      end
      load_en   = 1'b0;
      log_clear = 1'b0;
      repeat (5) @(negedge clk);
      rst_n = 1'b1;

      cycles = 0;
      while (int'(write_count) < n && cycles < 2000) begin
         @(negedge clk);
         cycles++;
      end
      if (int'(write_count) < n) begin
         timeout_errors++;
         $display("%s: timed out at %0t with %0d of %0d writes seen",
                  name, $time, write_count, n);
      end
      // the closing loop must stay quiet
      repeat (40) @(negedge clk);
      if (int'(write_count) > n) begin
         value_errors++;
         $display("%s: %0d more writes than expected", name, int'(write_count) - n);
      end
      for (int i = 0; i < n && i < int'(write_count); i++) begin
         check_addr(mem_model_inst.log_addr[8'(i)], exp_addr[i],
                    $sformatf("%s write %0d", name, i));
         check_data(mem_model_inst.log_data[8'(i)], exp_data[i],
                    $sformatf("%s write %0d", name, i));
      end
   endtask

   task automatic load_store_test();
      new_program();
      place_data(16'h0025, 8'h81);
      place_data(16'h0395, 8'h6e);
      op_byte(8'ha9, 8'h5a);      // LDA #
      op_byte(8'ha2, 8'hc3);      // LDX #
      op_byte(8'ha0, 8'h07);      // LDY #
      op_byte(8'h85, 8'h10);      // STA zpg
      op_byte(8'h86, 8'h11);      // STX zpg
      op_byte(8'h84, 8'h12);      // STY zpg
      op_byte(8'ha5, 8'h25);      // LDA zpg
      op_word(8'h8d, 16'h0390);   // STA abs
      op_word(8'had, 16'h0395);   // LDA abs
      op_byte(8'h85, 8'h13);
      expect_write(16'h0010, 8'h5a);
      expect_write(16'h0011, 8'hc3);
      expect_write(16'h0012, 8'h07);
      expect_write(16'h0390, 8'h81);
      expect_write(16'h0013, 8'h6e);
      run_program("load/store");
   endtask

   task automatic arith_test(input string name);
      logic [2:0]     aaa;
      cpu_pkg::data_t acc;
      cpu_pkg::data_t m;
      cpu_pkg::data_t zp_in;
      cpu_pkg::data_t zp_out;
      cpu_pkg::addr_t abs_in;
      logic           carry;
      int             k;
      new_program();
      k = 0;
      // four operations, each in immediate, zero page and absolute mode
      for (int op = 0; op < 4; op++) begin
         for (int mode = 0; mode < 3; mode++) begin
            aaa    = 3'(op);
            acc    = 8'(k * 53) + 8'h9a;
            m      = 8'(k * 29) ^ 8'h71;
            carry  = k[0];
            zp_in  = 8'h20 + 8'(k);
            zp_out = 8'h40 + 8'(k);
            abs_in = 16'h0380 + 16'(k);
            op_byte(8'ha9, acc);
            // SEC or CLC
            op_implied(carry ? 8'h38 : 8'h18);
            case (mode)
               0: op_byte({aaa, 3'b010, 2'b01}, m);
               1: begin
                  place_data({8'h00, zp_in}, m);
                  op_byte({aaa, 3'b001, 2'b01}, zp_in);
               end
               default: begin
                  place_data(abs_in, m);
                  op_word({aaa, 3'b011, 2'b01}, abs_in);
               end
            endcase
            op_byte(8'h85, zp_out);
            expect_write({8'h00, zp_out}, arith_result(aaa, acc, m, carry));
            k++;
         end
      end
      run_program(name);
   endtask

   task automatic compare_test();
      cpu_pkg::data_t acc [6] = '{8'h40, 8'h40, 8'h40, 8'h00, 8'hff, 8'h80};
      cpu_pkg::data_t m   [6] = '{8'h3f, 8'h40, 8'h41, 8'hff, 8'h00, 8'h7f};
      cpu_pkg::data_t res;
      new_program();
      for (int k = 0; k < 6; k++) begin
         op_byte(8'ha9, acc[k]);
         case (k % 3)
            0: op_byte(8'hc9, m[k]);
            1: begin
               place_data({8'h00, 8'h28 + 8'(k)}, m[k]);
               op_byte(8'hc5, 8'h28 + 8'(k));
            end
            default: begin
               place_data(16'h03a0 + 16'(k), m[k]);
               op_word(8'hcd, 16'h03a0 + 16'(k));
            end
         endcase
         // ADC #0 adds the compare carry
         op_byte(8'h69, 8'h00);
         op_byte(8'h85, 8'h50 + 8'(k));
         res = (acc[k] >= m[k]) ? acc[k] + 8'd1 : acc[k];
         expect_write({8'h00, 8'h50 + 8'(k)}, res);
      end
      run_program("compare");
   endtask

   task automatic index_test();
      cpu_pkg::data_t a;
      cpu_pkg::data_t x;
      cpu_pkg::data_t y;
      new_program();
      x = 8'hff;
      y = 8'h00;
      op_byte(8'ha2, x);
      op_byte(8'ha0, y);
      op_implied(8'he8);          // INX
      op_implied(8'h88);          // DEY
      x = x + 8'd1;
      y = y - 8'd1;
      op_byte(8'h86, 8'h60);
      op_byte(8'h84, 8'h61);
      expect_write(16'h0060, x);
      expect_write(16'h0061, y);
      op_implied(8'hc8);          // INY
      op_implied(8'hc8);
      op_implied(8'hca);          // DEX
      y = y + 8'd2;
      x = x - 8'd1;
      op_byte(8'h86, 8'h62);
      op_byte(8'h84, 8'h63);
      expect_write(16'h0062, x);
      expect_write(16'h0063, y);
      a = 8'h9d;
      op_byte(8'ha9, a);
      op_implied(8'haa);          // TAX
      op_implied(8'ha8);          // TAY
      op_byte(8'h86, 8'h64);
      op_byte(8'h84, 8'h65);
      expect_write(16'h0064, a);
      expect_write(16'h0065, a);
      x = 8'h12;
      op_byte(8'ha2, x);
      op_implied(8'h8a);          // TXA
      op_byte(8'h85, 8'h66);
      expect_write(16'h0066, x);
      y = 8'hfe;
      op_byte(8'ha0, y);
      op_implied(8'h98);          // TYA
      op_implied(8'hc8);
      op_byte(8'h85, 8'h67);
      op_byte(8'h84, 8'h68);
      expect_write(16'h0067, y);
      expect_write(16'h0068, y + 8'd1);
      run_program("index");
   endtask

   task automatic jump_test();
      cpu_pkg::addr_t target;
      new_program();
      op_byte(8'ha9, 8'ha7);
      op_byte(8'h85, 8'h70);
      // lands just past the two byte store
      target = here() + 16'd5;
      op_word(8'h4c, target);
      op_byte(8'h85, 8'h77);
      op_byte(8'ha2, 8'h3e);
      op_byte(8'h86, 8'h71);
      expect_write(16'h0070, 8'ha7);
      expect_write(16'h0071, 8'h3e);
      run_program("jump");
      for (int i = 0; i < int'(write_count); i++) begin
         if (mem_model_inst.log_addr[8'(i)] == 16'h0077) begin
            value_errors++;
            $display("jump: the skipped store at 0077 was executed");
         end
      end
   endtask

   initial begin
      rst_n          = 1'b0;
      wait_en        = 1'b0;
      load_en        = 1'b0;
      load_addr      = '0;
      load_data      = '0;
      log_clear      = 1'b1;
      value_errors   = 0;
      timeout_errors = 0;

      load_store_test();
      arith_test("arith");
      compare_test();
      index_test();
      jump_test();
      // same arithmetic under random back-pressure
      wait_en = 1'b1;
      arith_test("arith with wait states");

      $display("value errors: %0d, timeouts: %0d", value_errors, timeout_errors);
      if (value_errors == 0 && timeout_errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
verilog/cpu_pkg.sv
verilog/cpu_alu.sv
verilog/cpu_ctrl_rom.sv
verilog/cpu_sequencer.sv
verilog/cpu_datapath.sv
verilog/cpu_apb_master.sv
verilog/cpu_top.sv
sim/apb_mem_model.sv
sim/tb_cpu_top.sv

//--- Makefile
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module cpu_top -f src.f
	verilator --lint-only --timing --top-module tb_cpu_top -f src.f

sim:
	verilator --binary --timing --top-module tb_cpu_top -f src.f -o sim_cpu
	./obj_dir/sim_cpu > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
